// ==== rtl/vread_types_pkg.sv ====
package vread_types_pkg;

   // words per bank is 2**BUF_AW
   localparam int BUF_AW = 6;

   typedef logic [31:0] word_t;
   typedef logic [31:0] ext_addr_t;
   typedef logic [BUF_AW-1:0] buf_addr_t;

   // counts must hold a full bank (64)
   typedef logic [6:0] count_t;
   typedef logic [6:0] period_t;

   typedef struct packed {
      // fetch side
      ext_addr_t ext_addr;
      count_t    amount_minus_one;
      count_t    burst_len;
      // bank selection
      logic      pingpong;
      // output pattern
      buf_addr_t start;
      buf_addr_t incr;
      buf_addr_t shift;
      count_t    iter;
      period_t   per;
      period_t   duty;
   } run_cfg_t;

endpackage

// ==== rtl/vread_bus_pkg.sv ====
package vread_bus_pkg;

   import vread_types_pkg::*;

   // burst request towards external memory
   typedef struct packed {
      logic      valid;
      ext_addr_t addr;
      count_t    len;
   } bus_req_t;

   // request accept plus per-word return
   typedef struct packed {
      logic  ready;
      logic  rvalid;
      word_t rdata;
      logic  rlast;
   } bus_rsp_t;

   // buffer write port with an index into the fill bank
   typedef struct packed {
      logic      we;
      buf_addr_t addr;
      word_t     data;
   } buf_wr_t;

   // buffer read port with an index into the read bank
   typedef struct packed {
      logic      re;
      buf_addr_t addr;
   } buf_rd_t;

endpackage

// ==== rtl/vread_fetch.sv ====
module vread_fetch
   import vread_types_pkg::*;
   import vread_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run_i,
   input  run_cfg_t cfg_i,
   output bus_req_t bus_req_o,
   input  bus_rsp_t bus_rsp_i,
   output buf_wr_t  wr_o,
   output logic     done_o
);

   typedef enum logic [1:0] {
      st_idle,
      st_request,
      st_receive
   } state_t;

   state_t state_q;
   count_t req_cnt_q;
   count_t rcv_cnt_q;
   count_t total;
   count_t remaining;
   count_t len;
   logic   accept;
   logic   beat;
   logic   last_beat;
   logic   all_requested;

   assign total     = cfg_i.amount_minus_one + count_t'(1);
   assign remaining = total - req_cnt_q;

   // final burst shortened to what is left
   assign len = (remaining < cfg_i.burst_len) ? remaining : cfg_i.burst_len;

   assign accept        = (state_q == st_request) && bus_rsp_i.ready;
   assign beat          = (state_q == st_receive) && bus_rsp_i.rvalid;
   assign last_beat     = beat && bus_rsp_i.rlast;
   assign all_requested = (req_cnt_q == total);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q   <= st_idle;
         req_cnt_q <= '0;
         rcv_cnt_q <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               if (run_i) begin
                  req_cnt_q <= '0;
                  rcv_cnt_q <= '0;
                  state_q   <= st_request;
               end
            end
            st_request: begin
               if (accept) begin
                  req_cnt_q <= req_cnt_q + len;
                  state_q   <= st_receive;
               end
            end
            st_receive: begin
               if (beat) begin
                  rcv_cnt_q <= rcv_cnt_q + count_t'(1);
               end
               // next burst only once this one is drained
               if (last_beat) begin
                  state_q <= all_requested ? st_idle : st_request;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // addr and len depend only on req_cnt_q, so they hold while waiting for ready
   always_comb begin
      bus_req_o.valid = (state_q == st_request);
      bus_req_o.addr  = cfg_i.ext_addr + ext_addr_t'({req_cnt_q, 2'b00});
      bus_req_o.len   = len;
   end

   // word n lands at index n
   always_comb begin
      wr_o.we   = beat;
      wr_o.addr = rcv_cnt_q[BUF_AW-1:0];
      wr_o.data = bus_rsp_i.rdata;
   end

   assign done_o = last_beat && all_requested;

endmodule

// ==== rtl/vread_outgen.sv ====
module vread_outgen
   import vread_types_pkg::*;
   import vread_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run_i,
   input  run_cfg_t cfg_i,
   output buf_rd_t  rd_o,
   output logic     done_o
);

   logic      active_q;
   logic      done_q;
   period_t   inner_q;
   count_t    outer_q;
   buf_addr_t base_q;
   buf_addr_t addr_q;
   logic      inner_last;
   logic      outer_last;
   logic      last_step;

   assign inner_last = (inner_q == cfg_i.per - period_t'(1));
   assign outer_last = (outer_q == cfg_i.iter - count_t'(1));
   assign last_step  = active_q && inner_last && outer_last;

   // loop counters
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active_q <= 1'b0;
         done_q   <= 1'b0;
         inner_q  <= '0;
         outer_q  <= '0;
      end else begin
         done_q <= last_step;
         if (run_i) begin
            active_q <= 1'b1;
            inner_q  <= '0;
            outer_q  <= '0;
         end else if (active_q) begin
            if (inner_last) begin
               inner_q <= '0;
               if (outer_last) begin
                  active_q <= 1'b0;
               end else begin
                  outer_q <= outer_q + count_t'(1);
               end
            end else begin
               inner_q <= inner_q + period_t'(1);
            end
         end
      end
   end

   // address path wrapping modulo bank size
   always_ff @(posedge clk) begin
      if (run_i) begin
         base_q <= cfg_i.start;
         addr_q <= cfg_i.start;
      end else if (active_q) begin
         if (inner_last) begin
            // new period rebased on outer address
            base_q <= base_q + cfg_i.shift;
            addr_q <= base_q + cfg_i.shift;
         end else begin
            addr_q <= addr_q + cfg_i.incr;
         end
      end
   end

   // strobe only inside the duty window
   always_comb begin
      rd_o.re   = active_q && (inner_q < cfg_i.duty);
      rd_o.addr = addr_q;
   end

   // delayed one cycle so it follows the last strobe
   assign done_o = done_q;

endmodule

// ==== rtl/vread_pingpong_buffer.sv ====
module vread_pingpong_buffer
   import vread_types_pkg::*;
   import vread_bus_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    run_i,
   input  logic    pingpong_i,
   input  buf_wr_t wr_i,
   input  buf_rd_t rd_i,
   input  logic    fetch_done_i,
   input  logic    out_done_i,
   output word_t   out_data_o,
   output logic    out_valid_o,
   output logic    done_o
);

   // two banks with the bank bit above the index
   word_t mem [2**(BUF_AW+1)];

   logic bank_q;
   logic wr_bank;
   logic rd_bank;
   logic fetch_done_q;
   logic out_done_q;

   // toggle per run with pingpong, else back to bank 0
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q <= 1'b0;
      end else if (run_i) begin
         bank_q <= pingpong_i ? ~bank_q : 1'b0;
      end
   end

   // fill opposite bank, read current one
   assign wr_bank = pingpong_i & ~bank_q;
   assign rd_bank = pingpong_i & bank_q;

   always_ff @(posedge clk) begin
      if (wr_i.we) begin
         mem[{wr_bank, wr_i.addr}] <= wr_i.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_i.re) begin
         out_data_o <= mem[{rd_bank, rd_i.addr}];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= rd_i.re;
      end
   end

   // both engines count as finished out of reset
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fetch_done_q <= 1'b1;
         out_done_q   <= 1'b1;
      end else if (run_i) begin
         fetch_done_q <= 1'b0;
         out_done_q   <= 1'b0;
      end else begin
         if (fetch_done_i) begin
            fetch_done_q <= 1'b1;
         end
         if (out_done_i) begin
            out_done_q <= 1'b1;
         end
      end
   end

   assign done_o = fetch_done_q & out_done_q;

endmodule

// ==== rtl/vread_top.sv ====
module vread_top
   import vread_types_pkg::*;
   import vread_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run_i,
   input  run_cfg_t cfg_i,
   output bus_req_t bus_req_o,
   input  bus_rsp_t bus_rsp_i,
   output word_t    out_data_o,
   output logic     out_valid_o,
   output logic     done_o
);

   buf_wr_t wr;
   buf_rd_t rd;
   logic    fetch_done;
   logic    out_done;

   vread_fetch fetch (
      .clk       (clk),
      .rst       (rst),
      .run_i     (run_i),
      .cfg_i     (cfg_i),
      .bus_req_o (bus_req_o),
      .bus_rsp_i (bus_rsp_i),
      .wr_o      (wr),
      .done_o    (fetch_done)
   );

   vread_outgen outgen (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (cfg_i),
      .rd_o   (rd),
      .done_o (out_done)
   );

   vread_pingpong_buffer buffer (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .pingpong_i   (cfg_i.pingpong),
      .wr_i         (wr),
      .rd_i         (rd),
      .fetch_done_i (fetch_done),
      .out_done_i   (out_done),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o),
      .done_o       (done_o)
   );

endmodule

// ==== verif/vread_clk_gen.sv ====
module vread_clk_gen (
   output logic clk_o
);

   // period of 100
   initial begin
      clk_o = 1'b0;
      forever begin
         #50 clk_o = ~clk_o;
      end
   end

endmodule

// ==== verif/vread_checker.sv ====
module vread_checker
   import vread_types_pkg::*;
   import vread_bus_pkg::*;
(
   input logic     clk,
   input logic     rst,
   input logic     run_i,
   input bus_req_t req_i,
   input bus_rsp_t rsp_i,
   input buf_rd_t  rd_i,
   input logic     valid_i,
   input logic     done_i
);

   int   fails = 0;
   logic receiving_q;

   // burst open from accept until its rlast
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         receiving_q <= 1'b0;
      end else if (req_i.valid && rsp_i.ready) begin
         receiving_q <= 1'b1;
      end else if (rsp_i.rvalid && rsp_i.rlast) begin
         receiving_q <= 1'b0;
      end
   end

   valid_after_strobe: assert property (@(posedge clk) disable iff (rst)
      valid_i == $past(rd_i.re))
   else begin
      fails++;
      $error("out_valid_o does not follow the read strobe by one cycle");
   end

   done_falls_after_run: assert property (@(posedge clk) disable iff (rst)
      run_i |=> !done_i)
   else begin
      fails++;
      $error("done_o did not fall the cycle after run_i");
   end

   req_held_until_ready: assert property (@(posedge clk) disable iff (rst)
      req_i.valid && !rsp_i.ready |=>
         req_i.valid && $stable(req_i.addr) && $stable(req_i.len))
   else begin
      fails++;
      $error("bus request changed while waiting for ready");
   end

   no_req_in_burst: assert property (@(posedge clk) disable iff (rst)
      receiving_q |-> !req_i.valid)
   else begin
      fails++;
      $error("bus request raised while a burst is still receiving");
   end

endmodule

// ==== verif/vread_tb.sv ====
module vread_tb
   import vread_types_pkg::*;
   import vread_bus_pkg::*;
();

   localparam logic [31:0] SEED = 32'h1fb8_edbf;
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        rst;
   logic        run;
   run_cfg_t    cfg;
   bus_req_t    req;
   bus_rsp_t    rsp;
   word_t       out_data;
   logic        out_valid;
   logic        done;

   logic [31:0] rnd_state;
   logic        bank_state;
   logic        timed_out;
   word_t       model [128];
   word_t       expect_q [$];
   logic [31:0] exp_addr_q [$];
   int          exp_len_q [$];
   logic [31:0] got_addr_q [$];
   int          got_len_q [$];
   int          errors;
   int          runs;

   vread_clk_gen clk_gen (
      .clk_o (clk)
   );

   vread_top uut (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run),
      .cfg_i       (cfg),
      .bus_req_o   (req),
      .bus_rsp_i   (rsp),
      .out_data_o  (out_data),
      .out_valid_o (out_valid),
      .done_o      (done)
   );

   bind vread_top vread_checker chk (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .req_i   (bus_req_o),
      .rsp_i   (bus_rsp_i),
      .rd_i    (rd),
      .valid_i (out_valid_o),
      .done_i  (done_o)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   // memory word is a function of its byte address
   function automatic word_t mem_word(input ext_addr_t a);
      return lcg_next(a);
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // expected bank, output words and bursts of one run, then the new fill data
   function automatic void predict_run(input run_cfg_t c);
      int        total;
      int        len;
      int        n;
      int        i;
      int        j;
      logic      rd_b;
      logic      wr_b;
      buf_addr_t idx;
      if (c.pingpong) begin
         bank_state = ~bank_state;
         rd_b       = bank_state;
         wr_b       = ~bank_state;
      end else begin
         bank_state = 1'b0;
         rd_b       = 1'b0;
         wr_b       = 1'b0;
      end
      for (j = 0; j < int'(c.iter); j++) begin
         for (i = 0; i < int'(c.per); i++) begin
            if (i < int'(c.duty)) begin
               idx = buf_addr_t'(int'(c.start) + j * int'(c.shift) + i * int'(c.incr));
               expect_q.push_back(model[{rd_b, idx}]);
            end
         end
      end
      total = int'(c.amount_minus_one) + 1;
      for (n = 0; n < total; n += len) begin
         len = (total - n < int'(c.burst_len)) ? total - n : int'(c.burst_len);
         exp_addr_q.push_back(c.ext_addr + 32'(4 * n));
         exp_len_q.push_back(len);
      end
      for (n = 0; n < total; n++) begin
         model[{wr_b, buf_addr_t'(n)}] = mem_word(c.ext_addr + 32'(4 * n));
      end
   endfunction

   function automatic run_cfg_t make_cfg(input ext_addr_t addr, input int words,
                                         input int burst, input logic pp, input int start,
                                         input int incr, input int shift, input int iter,
                                         input int per, input int duty);
      run_cfg_t c;
      c.ext_addr         = addr;
      c.amount_minus_one = count_t'(words - 1);
      c.burst_len        = count_t'(burst);
      c.pingpong         = pp;
      c.start            = buf_addr_t'(start);
      c.incr             = buf_addr_t'(incr);
      c.shift            = buf_addr_t'(shift);
      c.iter             = count_t'(iter);
      c.per              = period_t'(per);
      c.duty             = period_t'(duty);
      return c;
   endfunction

   task automatic wait_done(input string name);
      int cycles;
      cycles = 0;
      while (!done && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
      end
      if (!done) begin
         timed_out = 1'b1;
         $display("timeout: done_o never rose in test %s", name);
      end
   endtask

   task automatic do_run(input string name, input run_cfg_t c);
      int errs_before;
      if (timed_out) begin
         return;
      end
      errs_before = errors;
      predict_run(c);
      @(posedge clk);
      #1;
      cfg = c;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      wait_done(name);
      if (timed_out) begin
         return;
      end
      check_value("request count", got_addr_q.size(), exp_addr_q.size());
      while (got_addr_q.size() > 0 && exp_addr_q.size() > 0) begin
         check_value("bus_req_o.addr", got_addr_q.pop_front(), exp_addr_q.pop_front());
         check_value("bus_req_o.len", got_len_q.pop_front(), exp_len_q.pop_front());
      end
      got_addr_q.delete();
      got_len_q.delete();
      exp_addr_q.delete();
      exp_len_q.delete();
      check_value("missing output words", expect_q.size(), 0);
      expect_q.delete();
      runs++;
      $display("test %s: %0d errors", name, errors - errs_before);
   endtask

   // burst memory with random accept delay and random beat gaps
   initial begin : bus_model
      int        beats_left;
      ext_addr_t beat_addr;
      beats_left = 0;
      beat_addr  = '0;
      rnd_state  = SEED;
      rsp        = '0;
      forever begin
         @(posedge clk);
         #1;
         rnd_state  = lcg_next(rnd_state);
         rsp.ready  = 1'b0;
         rsp.rvalid = 1'b0;
         rsp.rlast  = 1'b0;
         if (beats_left > 0) begin
            if (rnd_state[31]) begin
               rsp.rvalid = 1'b1;
               rsp.rdata  = mem_word(beat_addr);
               beats_left--;
               rsp.rlast  = (beats_left == 0);
               beat_addr  = beat_addr + 32'd4;
            end
         end else if (req.valid && rnd_state[30:29] == 2'b00) begin
            rsp.ready  = 1'b1;
            beats_left = int'(req.len);
            beat_addr  = req.addr;
            got_addr_q.push_back(req.addr);
            got_len_q.push_back(int'(req.len));
         end
      end
   end

   always @(negedge clk) begin
      if (out_valid) begin
         if (expect_q.size() == 0) begin
            errors++;
            $display("unexpected output word %h at %0t", out_data, $time);
         end else begin
            check_value("out_data_o", out_data, expect_q.pop_front());
         end
      end
   end

   initial begin
      int total_errors;
      errors     = 0;
      runs       = 0;
      bank_state = 1'b0;
      timed_out  = 1'b0;
      rst        = 1'b1;
      run        = 1'b0;
      cfg        = '0;
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_value("done_o", 32'(done), 32'd1);
      check_value("out_valid_o", 32'(out_valid), 32'd0);
      check_value("bus_req_o.valid", 32'(req.valid), 32'd0);
      $display("test reset: %0d errors", errors);

      // duty 0 runs only fill the buffer
      do_run("fill", make_cfg(32'h0000_1000, 32, 8, 1'b0, 0, 0, 0, 1, 1, 0));
      do_run("in_order", make_cfg(32'h0000_1000, 16, 4, 1'b0, 0, 1, 0, 1, 16, 16));
      do_run("short_burst", make_cfg(32'h0000_2040, 10, 4, 1'b0, 16, 1, 0, 1, 8, 8));
      do_run("two_level", make_cfg(32'h0000_2040, 10, 3, 1'b0, 1, 2, 8, 3, 5, 3));
      do_run("pp_fill", make_cfg(32'h0001_0000, 16, 5, 1'b1, 0, 0, 0, 1, 1, 0));
      do_run("pp_swap", make_cfg(32'h0001_0400, 16, 16, 1'b1, 0, 1, 8, 2, 8, 8));
      do_run("pp_swap_again", make_cfg(32'h0003_00fc, 16, 7, 1'b1, 0, 1, 8, 2, 8, 8));

      total_errors = errors + uut.chk.fails;
      $display("summary: %0d runs, %0d check errors, %0d assertion failures",
               runs, errors, uut.chk.fails);
      if (total_errors == 0 && !timed_out) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
rtl/vread_types_pkg.sv
rtl/vread_bus_pkg.sv
rtl/vread_fetch.sv
rtl/vread_outgen.sv
rtl/vread_pingpong_buffer.sv
rtl/vread_top.sv
verif/vread_clk_gen.sv
verif/vread_checker.sv
verif/vread_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module vread_tb -f all.f -o vread_sim

# keep running after an assertion error so the testbench can report it
output=$(./obj_dir/vread_sim +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
   exit 0
fi
exit 1
